// ==== Bender.yml ====
package:
  name: mmu_lite

sources:
  - common/mmu_lite_pkg.sv
  - tlb/tlb.sv
  - logic/instr_translate.sv
  - logic/data_translate.sv
  - logic/refill_arbiter.sv
  - logic/mmu_lite_top.sv
  - target: test
    files:
      - verification/mmu_lite_tb.sv

// ==== common/mmu_lite_pkg.sv ====
// ----------------------------------------
// shared widths, typedefs and enums for the
// Sv39 translation unit with 4 KiB pages
// ----------------------------------------
`default_nettype none

package mmu_lite_pkg;

    // address geometry
    localparam int unsigned VLen           = 39;
    localparam int unsigned PLen           = 34;
    localparam int unsigned PageOffsetBits = 12;
    // vpn is vaddr[38:12], ppn is the upper part of paddr
    localparam int unsigned VpnBits        = VLen - PageOffsetBits;
    localparam int unsigned PpnBits        = PLen - PageOffsetBits;

    // tlb sizes
    localparam int unsigned ItlbEntries = 4;
    localparam int unsigned DtlbEntries = 4;

    // bit positions inside pte_flags_t, order is v, u, w, d
    localparam int unsigned FlagV = 3;
    localparam int unsigned FlagU = 2;
    localparam int unsigned FlagW = 1;
    localparam int unsigned FlagD = 0;

    typedef logic [VLen-1:0]    vaddr_t;
    typedef logic [PLen-1:0]    paddr_t;
    typedef logic [VpnBits-1:0] vpn_t;
    typedef logic [PpnBits-1:0] ppn_t;
    typedef logic [3:0]         pte_flags_t;

    typedef enum logic [1:0] {
        PrivU = 2'd0,
        PrivS = 2'd1,
        PrivM = 2'd3
    } priv_lvl_t;

    // exception codes as in the privileged spec
    typedef enum logic [3:0] {
        CauseNone      = 4'd0,
        InstrPageFault = 4'd12,
        LoadPageFault  = 4'd13,
        StorePageFault = 4'd15
    } cause_t;

    // refill handshake phases
    typedef enum logic [1:0] {
        RfIdle,
        RfReq,
        RfRelease
    } refill_state_t;

endpackage

`default_nettype wire

// ==== logic/data_translate.sv ====
// ----------------------------------------
// registered load/store translation with
// store, dirty and SUM rules
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module data_translate (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    enable_i,
    // lsu request
    input  logic                    lsu_req_i,
    input  mmu_lite_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                    lsu_is_store_i,
    input  mmu_lite_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                    sum_i,
    // dtlb answer
    input  logic                    tlb_hit_i,
    input  mmu_lite_pkg::ppn_t       tlb_ppn_i,
    input  mmu_lite_pkg::pte_flags_t tlb_flags_i,
    input  logic                    fault_i,
    // dtlb lookup and refill request
    output mmu_lite_pkg::vpn_t       lookup_vpn_o,
    output logic                    miss_o,
    output mmu_lite_pkg::vpn_t       miss_vpn_o,
    // lsu response, one cycle after the request
    output logic                    lsu_valid_o,
    output mmu_lite_pkg::paddr_t     lsu_paddr_o,
    output mmu_lite_pkg::cause_t     lsu_cause_o
);
    import mmu_lite_pkg::*;

    logic       req_q;
    logic       hit_q;
    logic       is_store_q;
    vaddr_t     vaddr_q;
    ppn_t       ppn_q;
    pte_flags_t flags_q;
    logic       daccess_err;

    assign lookup_vpn_o = lsu_vaddr_i[VLen-1:PageOffsetBits];
    assign miss_vpn_o   = vaddr_q[VLen-1:PageOffsetBits];

    // ----------------------------------------
    // request and tlb result registers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= tlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        ppn_q      <= tlb_ppn_i;
        flags_q    <= tlb_flags_i;
    end

    // ----------------------------------------
    // load/store rules on the registered entry
    // ----------------------------------------
    // s touches u pages only with SUM, u never leaves u pages
    assign daccess_err = ((priv_lvl_i == PrivS) && !sum_i && flags_q[FlagU])
                      || ((priv_lvl_i == PrivU) && !flags_q[FlagU]);

    always_comb begin
        lsu_valid_o = req_q;
        lsu_paddr_o = vaddr_q[PLen-1:0];
        lsu_cause_o = CauseNone;
        miss_o      = 1'b0;
        if (enable_i) begin
            lsu_valid_o = 1'b0;
            lsu_paddr_o = {ppn_q, vaddr_q[PageOffsetBits-1:0]};
            if (req_q && hit_q) begin
                lsu_valid_o = 1'b1;
                if (is_store_q) begin
                    // stores also need a writable, already dirty page
                    if (!flags_q[FlagW] || !flags_q[FlagD] || daccess_err) begin
                        lsu_cause_o = StorePageFault;
                    end
                end else if (daccess_err) begin
                    lsu_cause_o = LoadPageFault;
                end
            end else if (req_q) begin
                miss_o = 1'b1;
                // unmapped page ends the request with a fault
                if (fault_i) begin
                    lsu_valid_o = 1'b1;
                    lsu_cause_o = is_store_q ? StorePageFault : LoadPageFault;
                end
            end
        end
    end

    // a fault pulse only answers a registered request that missed
    a_fault_on_miss : assert property (@(posedge clk_i) disable iff (!rst_ni)
        fault_i |-> (enable_i && req_q && !hit_q));

endmodule

`default_nettype wire

// ==== logic/instr_translate.sv ====
// ----------------------------------------
// fetch translation and privilege check,
// answered in the request cycle
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_translate (
    input  logic                    enable_i,
    // fetch request
    input  logic                    fetch_req_i,
    input  mmu_lite_pkg::vaddr_t     fetch_vaddr_i,
    input  mmu_lite_pkg::priv_lvl_t  priv_lvl_i,
    // itlb answer
    input  logic                    tlb_hit_i,
    input  mmu_lite_pkg::ppn_t       tlb_ppn_i,
    input  mmu_lite_pkg::pte_flags_t tlb_flags_i,
    input  logic                    fault_i,
    // fetch response
    output logic                    fetch_valid_o,
    output mmu_lite_pkg::paddr_t     fetch_paddr_o,
    output mmu_lite_pkg::cause_t     fetch_cause_o,
    // itlb lookup and refill request
    output mmu_lite_pkg::vpn_t       lookup_vpn_o,
    output logic                    miss_o,
    output mmu_lite_pkg::vpn_t       miss_vpn_o
);
    import mmu_lite_pkg::*;

    logic iaccess_err;

    assign lookup_vpn_o = fetch_vaddr_i[VLen-1:PageOffsetBits];
    assign miss_vpn_o   = lookup_vpn_o;

    // user code only on u pages, supervisor code never on u pages
    assign iaccess_err = ((priv_lvl_i == PrivU) && !tlb_flags_i[FlagU])
                      || ((priv_lvl_i == PrivS) && tlb_flags_i[FlagU]);

    always_comb begin
        // translation off, pass the low bits through
        fetch_valid_o = fetch_req_i;
        fetch_paddr_o = fetch_vaddr_i[PLen-1:0];
        fetch_cause_o = CauseNone;
        miss_o        = 1'b0;
        if (enable_i) begin
            fetch_paddr_o = {tlb_ppn_i, fetch_vaddr_i[PageOffsetBits-1:0]};
            if (tlb_hit_i) begin
                if (fetch_req_i && iaccess_err) begin
                    fetch_cause_o = InstrPageFault;
                end
            end else begin
                // hold the fetch until the refill lands or faults
                miss_o        = fetch_req_i;
                fetch_valid_o = fetch_req_i && fault_i;
                if (fetch_req_i && fault_i) begin
                    fetch_cause_o = InstrPageFault;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mmu_lite_top.sv ====
// ----------------------------------------
// top level with both tlbs, both paths
// and the refill arbiter
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mmu_lite_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    enable_i,
    input  logic                    flush_i,
    input  mmu_lite_pkg::priv_lvl_t  priv_lvl_i,
    input  mmu_lite_pkg::priv_lvl_t  ld_st_priv_lvl_i,
    input  logic                    sum_i,
    // fetch side
    input  logic                    fetch_req_i,
    input  mmu_lite_pkg::vaddr_t     fetch_vaddr_i,
    output logic                    fetch_valid_o,
    output mmu_lite_pkg::paddr_t     fetch_paddr_o,
    output mmu_lite_pkg::cause_t     fetch_cause_o,
    // lsu side
    input  logic                    lsu_req_i,
    input  mmu_lite_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                    lsu_is_store_i,
    output logic                    lsu_valid_o,
    output mmu_lite_pkg::paddr_t     lsu_paddr_o,
    output mmu_lite_pkg::cause_t     lsu_cause_o,
    // refill port
    output logic                    refill_req_o,
    output mmu_lite_pkg::vpn_t       refill_vpn_o,
    output logic                    refill_is_instr_o,
    input  logic                    refill_ack_i,
    input  mmu_lite_pkg::ppn_t       refill_ppn_i,
    input  mmu_lite_pkg::pte_flags_t refill_flags_i
);
    import mmu_lite_pkg::*;

    // instruction side wires
    vpn_t       itlb_vpn;
    logic       itlb_hit;
    ppn_t       itlb_ppn;
    pte_flags_t itlb_flags;
    logic       imiss;
    vpn_t       imiss_vpn;
    logic       ifault;
    logic       itlb_upd_valid;
    // data side wires
    vpn_t       dtlb_vpn;
    logic       dtlb_hit;
    ppn_t       dtlb_ppn;
    pte_flags_t dtlb_flags;
    logic       dmiss;
    vpn_t       dmiss_vpn;
    logic       dfault;
    logic       dtlb_upd_valid;
    // shared refill payload
    vpn_t       upd_vpn;
    ppn_t       upd_ppn;
    pte_flags_t upd_flags;

    tlb #(
        .NrEntries    ( ItlbEntries    )
    ) i_itlb (
        .clk_i        ( clk_i          ),
        .rst_ni       ( rst_ni         ),
        .flush_i      ( flush_i        ),
        .lookup_vpn_i ( itlb_vpn       ),
        .hit_o        ( itlb_hit       ),
        .ppn_o        ( itlb_ppn       ),
        .flags_o      ( itlb_flags     ),
        .upd_valid_i  ( itlb_upd_valid ),
        .upd_vpn_i    ( upd_vpn        ),
        .upd_ppn_i    ( upd_ppn        ),
        .upd_flags_i  ( upd_flags      )
    );

    tlb #(
        .NrEntries    ( DtlbEntries    )
    ) i_dtlb (
        .clk_i        ( clk_i          ),
        .rst_ni       ( rst_ni         ),
        .flush_i      ( flush_i        ),
        .lookup_vpn_i ( dtlb_vpn       ),
        .hit_o        ( dtlb_hit       ),
        .ppn_o        ( dtlb_ppn       ),
        .flags_o      ( dtlb_flags     ),
        .upd_valid_i  ( dtlb_upd_valid ),
        .upd_vpn_i    ( upd_vpn        ),
        .upd_ppn_i    ( upd_ppn        ),
        .upd_flags_i  ( upd_flags      )
    );

    instr_translate i_instr (
        .enable_i      ( enable_i      ),
        .fetch_req_i   ( fetch_req_i   ),
        .fetch_vaddr_i ( fetch_vaddr_i ),
        .priv_lvl_i    ( priv_lvl_i    ),
        .tlb_hit_i     ( itlb_hit      ),
        .tlb_ppn_i     ( itlb_ppn      ),
        .tlb_flags_i   ( itlb_flags    ),
        .fault_i       ( ifault        ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_paddr_o ( fetch_paddr_o ),
        .fetch_cause_o ( fetch_cause_o ),
        .lookup_vpn_o  ( itlb_vpn      ),
        .miss_o        ( imiss         ),
        .miss_vpn_o    ( imiss_vpn     )
    );

    data_translate i_data (
        .clk_i          ( clk_i            ),
        .rst_ni         ( rst_ni           ),
        .enable_i       ( enable_i         ),
        .lsu_req_i      ( lsu_req_i        ),
        .lsu_vaddr_i    ( lsu_vaddr_i      ),
        .lsu_is_store_i ( lsu_is_store_i   ),
        .priv_lvl_i     ( ld_st_priv_lvl_i ),
        .sum_i          ( sum_i            ),
        .tlb_hit_i      ( dtlb_hit         ),
        .tlb_ppn_i      ( dtlb_ppn         ),
        .tlb_flags_i    ( dtlb_flags       ),
        .fault_i        ( dfault           ),
        .lookup_vpn_o   ( dtlb_vpn         ),
        .miss_o         ( dmiss            ),
        .miss_vpn_o     ( dmiss_vpn        ),
        .lsu_valid_o    ( lsu_valid_o      ),
        .lsu_paddr_o    ( lsu_paddr_o      ),
        .lsu_cause_o    ( lsu_cause_o      )
    );

    refill_arbiter i_refill (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .imiss_i           ( imiss             ),
        .imiss_vpn_i       ( imiss_vpn         ),
        .dmiss_i           ( dmiss             ),
        .dmiss_vpn_i       ( dmiss_vpn         ),
        .refill_req_o      ( refill_req_o      ),
        .refill_vpn_o      ( refill_vpn_o      ),
        .refill_is_instr_o ( refill_is_instr_o ),
        .refill_ack_i      ( refill_ack_i      ),
        .refill_ppn_i      ( refill_ppn_i      ),
        .refill_flags_i    ( refill_flags_i    ),
        .itlb_upd_valid_o  ( itlb_upd_valid    ),
        .dtlb_upd_valid_o  ( dtlb_upd_valid    ),
        .upd_vpn_o         ( upd_vpn           ),
        .upd_ppn_o         ( upd_ppn           ),
        .upd_flags_o       ( upd_flags         ),
        .ifault_o          ( ifault            ),
        .dfault_o          ( dfault            )
    );

endmodule

`default_nettype wire

// ==== logic/refill_arbiter.sv ====
// ----------------------------------------
// merges itlb and dtlb misses into one
// four-phase refill port, routes answers
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module refill_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // misses from both paths
    input  logic                    imiss_i,
    input  mmu_lite_pkg::vpn_t       imiss_vpn_i,
    input  logic                    dmiss_i,
    input  mmu_lite_pkg::vpn_t       dmiss_vpn_i,
    // external refill port
    output logic                    refill_req_o,
    output mmu_lite_pkg::vpn_t       refill_vpn_o,
    output logic                    refill_is_instr_o,
    input  logic                    refill_ack_i,
    input  mmu_lite_pkg::ppn_t       refill_ppn_i,
    input  mmu_lite_pkg::pte_flags_t refill_flags_i,
    // tlb writes and fault pulses
    output logic                    itlb_upd_valid_o,
    output logic                    dtlb_upd_valid_o,
    output mmu_lite_pkg::vpn_t       upd_vpn_o,
    output mmu_lite_pkg::ppn_t       upd_ppn_o,
    output mmu_lite_pkg::pte_flags_t upd_flags_o,
    output logic                    ifault_o,
    output logic                    dfault_o
);
    import mmu_lite_pkg::*;

    refill_state_t state_q;
    vpn_t          vpn_q;
    logic          is_instr_q;
    logic          take;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= RfIdle;
            vpn_q      <= '0;
            is_instr_q <= 1'b0;
        end else begin
            case (state_q)
                // data wins when both miss together
                RfIdle: begin
                    if (dmiss_i) begin
                        vpn_q      <= dmiss_vpn_i;
                        is_instr_q <= 1'b0;
                        state_q    <= RfReq;
                    end else if (imiss_i) begin
                        vpn_q      <= imiss_vpn_i;
                        is_instr_q <= 1'b1;
                        state_q    <= RfReq;
                    end
                end
                RfReq: begin
                    if (refill_ack_i) begin
                        state_q <= RfRelease;
                    end
                end
                // wait for the agent to drop ack
                RfRelease: begin
                    if (!refill_ack_i) begin
                        state_q <= RfIdle;
                    end
                end
                default: state_q <= RfIdle;
            endcase
        end
    end

    assign refill_req_o      = (state_q == RfReq);
    assign refill_vpn_o      = vpn_q;
    assign refill_is_instr_o = is_instr_q;

    // answer taken in the first cycle ack is seen
    assign take             = refill_req_o && refill_ack_i;
    assign itlb_upd_valid_o = take && is_instr_q && refill_flags_i[FlagV];
    assign dtlb_upd_valid_o = take && !is_instr_q && refill_flags_i[FlagV];
    assign ifault_o         = take && is_instr_q && !refill_flags_i[FlagV];
    assign dfault_o         = take && !is_instr_q && !refill_flags_i[FlagV];
    assign upd_vpn_o        = vpn_q;
    assign upd_ppn_o        = refill_ppn_i;
    assign upd_flags_o      = refill_flags_i;

    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (refill_req_o && $past(refill_req_o))
            |-> ($stable(refill_vpn_o) && $stable(refill_is_instr_o)));

endmodule

`default_nettype wire

// ==== mmu_lite.f ====
common/mmu_lite_pkg.sv
tlb/tlb.sv
logic/instr_translate.sv
logic/data_translate.sv
logic/refill_arbiter.sv
logic/mmu_lite_top.sv
verification/mmu_lite_tb.sv

// ==== tlb/tlb.sv ====
// ----------------------------------------
// fully associative tlb with same-cycle
// lookup, flush and round-robin refill
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tlb #(
    parameter int unsigned NrEntries = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // lookup port
    input  mmu_lite_pkg::vpn_t       lookup_vpn_i,
    output logic                    hit_o,
    output mmu_lite_pkg::ppn_t       ppn_o,
    output mmu_lite_pkg::pte_flags_t flags_o,
    // refill port
    input  logic                    upd_valid_i,
    input  mmu_lite_pkg::vpn_t       upd_vpn_i,
    input  mmu_lite_pkg::ppn_t       upd_ppn_i,
    input  mmu_lite_pkg::pte_flags_t upd_flags_i
);
    import mmu_lite_pkg::*;

    localparam int unsigned IdxBits = (NrEntries > 1) ? $clog2(NrEntries) : 1;

    vpn_t                 tag_q   [NrEntries];
    ppn_t                 ppn_q   [NrEntries];
    pte_flags_t           flags_q [NrEntries];
    logic [NrEntries-1:0] valid_q;
    logic [NrEntries-1:0] hit_vec;
    logic [NrEntries-1:0] upd_match;
    logic [IdxBits-1:0]   victim_q;
    logic [IdxBits-1:0]   upd_idx;

    // parallel tag compare for lookup and for the incoming refill
    always_comb begin
        ppn_o   = '0;
        flags_o = '0;
        upd_idx = victim_q;
        for (int i = 0; i < NrEntries; i++) begin
            hit_vec[i]   = valid_q[i] && (tag_q[i] == lookup_vpn_i);
            upd_match[i] = valid_q[i] && (tag_q[i] == upd_vpn_i);
            if (hit_vec[i]) begin
                ppn_o   = ppn_q[i];
                flags_o = flags_q[i];
            end
            // a refill of a vpn already held overwrites that slot
            if (upd_match[i]) begin
                upd_idx = IdxBits'(i);
            end
        end
    end

    assign hit_o = |hit_vec;

    // valid bits and victim pointer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            // refill wins over a flush in the same cycle
            if (upd_valid_i) begin
                valid_q[upd_idx] <= 1'b1;
                if (!(|upd_match)) begin
                    victim_q <= (victim_q == IdxBits'(NrEntries - 1)) ? '0 : victim_q + 1'b1;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            tag_q[upd_idx]   <= upd_vpn_i;
            ppn_q[upd_idx]   <= upd_ppn_i;
            flags_q[upd_idx] <= upd_flags_i;
        end
    end

    // a vpn is never held twice, so lookups stay unambiguous
    a_onehot_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== verification/mmu_lite_tb.sv ====
// ----------------------------------------
// testbench for the translation unit, plays
// the refill agent from a page table file
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mmu_lite_tb;
    import mmu_lite_pkg::*;

    logic       clk_i;
    logic       rst_ni;
    logic       enable_i;
    logic       flush_i;
    priv_lvl_t  priv_lvl_i;
    priv_lvl_t  ld_st_priv_lvl_i;
    logic       sum_i;
    logic       fetch_req_i;
    vaddr_t     fetch_vaddr_i;
    logic       fetch_valid_o;
    paddr_t     fetch_paddr_o;
    cause_t     fetch_cause_o;
    logic       lsu_req_i;
    vaddr_t     lsu_vaddr_i;
    logic       lsu_is_store_i;
    logic       lsu_valid_o;
    paddr_t     lsu_paddr_o;
    cause_t     lsu_cause_o;
    logic       refill_req_o;
    vpn_t       refill_vpn_o;
    logic       refill_is_instr_o;
    logic       refill_ack_i;
    ppn_t       refill_ppn_i;
    pte_flags_t refill_flags_i;

    // page table held by the agent
    vpn_t        pt_vpn   [16];
    ppn_t        pt_ppn   [16];
    pte_flags_t  pt_flags [16];
    int          pt_count;
    // side of every refill served, 1 for fetch
    logic        refill_log [$];
    int          mismatch_count;
    int          fail_count;
    int unsigned cycle_limit;

    mmu_lite_top dut (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .enable_i          ( enable_i          ),
        .flush_i           ( flush_i           ),
        .priv_lvl_i        ( priv_lvl_i        ),
        .ld_st_priv_lvl_i  ( ld_st_priv_lvl_i  ),
        .sum_i             ( sum_i             ),
        .fetch_req_i       ( fetch_req_i       ),
        .fetch_vaddr_i     ( fetch_vaddr_i     ),
        .fetch_valid_o     ( fetch_valid_o     ),
        .fetch_paddr_o     ( fetch_paddr_o     ),
        .fetch_cause_o     ( fetch_cause_o     ),
        .lsu_req_i         ( lsu_req_i         ),
        .lsu_vaddr_i       ( lsu_vaddr_i       ),
        .lsu_is_store_i    ( lsu_is_store_i    ),
        .lsu_valid_o       ( lsu_valid_o       ),
        .lsu_paddr_o       ( lsu_paddr_o       ),
        .lsu_cause_o       ( lsu_cause_o       ),
        .refill_req_o      ( refill_req_o      ),
        .refill_vpn_o      ( refill_vpn_o      ),
        .refill_is_instr_o ( refill_is_instr_o ),
        .refill_ack_i      ( refill_ack_i      ),
        .refill_ppn_i      ( refill_ppn_i      ),
        .refill_flags_i    ( refill_flags_i    )
    );

    // 8 ns period
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // checks and helpers
    // ----------------------------------------
    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // index of a vpn in the page table, -1 when unmapped
    function automatic int find_pte(input vpn_t vpn);
        int idx;
        idx = -1;
        for (int i = 0; i < pt_count; i++) begin
            if (pt_vpn[i] == vpn) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // new mode on a falling edge, flush is a one-cycle pulse
    task automatic set_mode(input logic en, input priv_lvl_t priv, input logic sum,
                            input logic flush);
        @(negedge clk_i);
        enable_i         = en;
        priv_lvl_i       = priv;
        ld_st_priv_lvl_i = priv;
        sum_i            = sum;
        flush_i          = flush;
        @(negedge clk_i);
        flush_i = 1'b0;
    endtask

    // fetch, lsu access or both; with both the fetch starts a cycle
    // later so its miss lines up with the registered data miss
    task automatic run_access(input logic use_f, input logic use_l, input logic store,
                              input vaddr_t f_va, input paddr_t f_pa, input cause_t f_c,
                              input vaddr_t l_va, input paddr_t l_pa, input cause_t l_c,
                              input int exp_refills);
        logic f_done;
        logic l_done;
        logic exp_side;
        int   first;
        int   served;
        first  = refill_log.size();
        f_done = !use_f;
        l_done = !use_l;
        @(negedge clk_i);
        if (use_l) begin
            lsu_req_i      = 1'b1;
            lsu_vaddr_i    = l_va;
            lsu_is_store_i = store;
        end else if (use_f) begin
            fetch_req_i   = 1'b1;
            fetch_vaddr_i = f_va;
        end
        while (!(f_done && l_done)) begin
            // outputs sampled at the rising edge, inputs moved on the falling one
            @(posedge clk_i);
            if (!f_done && fetch_req_i && fetch_valid_o) begin
                check_cause("fetch_cause_o", fetch_cause_o, f_c);
                // address only means something without a fault
                if (f_c == CauseNone) begin
                    check_paddr("fetch_paddr_o", fetch_paddr_o, f_pa);
                end
                f_done = 1'b1;
            end
            if (!l_done && lsu_req_i && lsu_valid_o) begin
                check_cause("lsu_cause_o", lsu_cause_o, l_c);
                if (l_c == CauseNone) begin
                    check_paddr("lsu_paddr_o", lsu_paddr_o, l_pa);
                end
                l_done = 1'b1;
            end
            @(negedge clk_i);
            if (f_done) begin
                fetch_req_i = 1'b0;
            end else if (!fetch_req_i) begin
                fetch_req_i   = 1'b1;
                fetch_vaddr_i = f_va;
            end
            if (l_done) begin
                lsu_req_i = 1'b0;
            end
        end
        // let the repeated lsu response and the handshake drain
        repeat (3) @(negedge clk_i);
        served = refill_log.size() - first;
        if (served != exp_refills) begin
            mismatch_count++;
            $display("MISMATCH refill_count: got 0x%h expected 0x%h", served, exp_refills);
        end
        // data is served first when both paths miss
        for (int i = 0; i < served; i++) begin
            exp_side = use_f && !(use_l && i == 0);
            if (refill_log[first + i] !== exp_side) begin
                mismatch_count++;
                $display("MISMATCH refill_is_instr_o: got 0x%h expected 0x%h",
                         refill_log[first + i], exp_side);
            end
        end
    endtask

    // ----------------------------------------
    // four-phase refill agent
    // ----------------------------------------
    initial begin : refill_agent
        int delay;
        int idx;
        void'($urandom(32'hb764));
        forever begin
            @(negedge clk_i);
            if (refill_req_o && !refill_ack_i) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge clk_i);
                idx            = find_pte(refill_vpn_o);
                refill_ppn_i   = (idx >= 0) ? pt_ppn[idx] : '0;
                refill_flags_i = (idx >= 0) ? pt_flags[idx] : '0;
                refill_ack_i   = 1'b1;
                refill_log.push_back(refill_is_instr_o);
                // hold ack until the request drops
                do begin
                    @(negedge clk_i);
                end while (refill_req_o);
                refill_ack_i = 1'b0;
            end
        end
    end

    // cycle counter that ends a stuck run
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        int          fd;
        int          n_access;
        string       line;
        string       lines [$];
        byte         kind;
        logic [63:0] a0;
        logic [63:0] a1;
        logic [63:0] a2;
        logic [63:0] a3;
        logic [63:0] a4;
        logic [63:0] a5;
        logic [63:0] a6;
        rst_ni           = 1'b0;
        enable_i         = 1'b0;
        flush_i          = 1'b0;
        priv_lvl_i       = PrivM;
        ld_st_priv_lvl_i = PrivM;
        sum_i            = 1'b0;
        fetch_req_i      = 1'b0;
        fetch_vaddr_i    = '0;
        lsu_req_i        = 1'b0;
        lsu_vaddr_i      = '0;
        lsu_is_store_i   = 1'b0;
        refill_ack_i     = 1'b0;
        refill_ppn_i     = '0;
        refill_flags_i   = '0;
        pt_count         = 0;
        mismatch_count   = 0;
        fail_count       = 0;
        n_access         = 0;
        fd = $fopen("verification/mmu_lite_testdata.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("could not open the test data file");
        end else begin
            // keep command lines, drop comments and blank lines
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                    if (line[0] == "F" || line[0] == "L" || line[0] == "S" || line[0] == "B") begin
                        n_access++;
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 200 * n_access + 50;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%c %h %h %h %h %h %h %h", kind, a0, a1, a2, a3, a4,
                          a5, a6));
            case (kind)
                "P": begin
                    pt_vpn[pt_count]   = a0[26:0];
                    pt_ppn[pt_count]   = a1[21:0];
                    pt_flags[pt_count] = a2[3:0];
                    pt_count++;
                end
                "M": set_mode(a0[0], priv_lvl_t'(a1[1:0]), a2[0], a3[0]);
                "F": run_access(1'b1, 1'b0, 1'b0, a0[38:0], a1[33:0], cause_t'(a2[3:0]),
                                '0, '0, CauseNone, int'(a3));
                "L": run_access(1'b0, 1'b1, 1'b0, '0, '0, CauseNone,
                                a0[38:0], a1[33:0], cause_t'(a2[3:0]), int'(a3));
                "S": run_access(1'b0, 1'b1, 1'b1, '0, '0, CauseNone,
                                a0[38:0], a1[33:0], cause_t'(a2[3:0]), int'(a3));
                "B": run_access(1'b1, 1'b1, 1'b0, a0[38:0], a1[33:0], cause_t'(a2[3:0]),
                                a3[38:0], a4[33:0], cause_t'(a5[3:0]), int'(a6));
                default: begin
                    fail_count++;
                    $display("unknown command in the test data: %s", lines[i]);
                end
            endcase
        end
        repeat (2) @(negedge clk_i);
        $display("run complete: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mmu_lite_testdata.txt ====
# P vpn ppn flags(v u w d) | M enable priv sum flush
# F/L/S vaddr paddr cause refills | B fvaddr fpaddr fcause lvaddr lpaddr lcause refills
# paddr is compared only when the cause is 0
P 00010 01234 b
P 00020 02345 f
P 00030 03456 8
P 00040 04567 a
M 0 1 0 0
F 7f00010abc 300010abc 0 0
L 1234567890 234567890 0 0
M 1 1 0 0
F 0000010123 001234123 0 1
F 0000010456 001234456 0 0
L 0000010800 001234800 0 1
S 0000010804 001234804 0 0
S 0000030010 000000000 f 1
S 0000040020 000000000 f 1
L 0000020030 000000000 d 1
M 1 1 1 0
L 0000020040 002345040 0 0
M 1 0 0 0
F 0000010200 000000000 c 0
F 0000020300 002345300 0 1
L 0000099000 000000000 d 1
F 0000099000 000000000 c 1
M 1 1 0 1
F 0000010123 001234123 0 1
B 0000030abc 003456abc 0 0000010ccc 001234ccc 0 2
